// File: hdl/soc_mem_pkg.sv
// shared definitions for the memory subsystem
// bus widths, core-local timer addresses, FSM state and target enums
`default_nettype none

package soc_mem_pkg;

    // single 64-bit beat per transaction
    localparam int ADDR_W = 64;
    localparam int DATA_W = 64;

    // core-local timer registers
    localparam logic [ADDR_W-1:0] MTIME_ADDR    = 64'h0200_BFF8;
    localparam logic [ADDR_W-1:0] MTIMECMP_ADDR = 64'h0200_4000;

    // arbiter FSM
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_REQ,
        ARB_WAIT
    } arb_state_e;

    // slave picked by the address decoder
    typedef enum logic {
        TGT_RAM,
        TGT_TIMER
    } bus_target_e;

    // RAM bridge FSM
    typedef enum logic [1:0] {
        BR_IDLE,
        BR_READ,
        BR_RESP
    } bridge_state_e;

endpackage

`default_nettype wire

// File: hdl/mem_arbiter.sv
// fetch/data arbiter with data priority
// single outstanding master on the internal bus, one-cycle acks
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
    input  wire                             clk,
    input  wire                             i_arst_n,
    input  wire                             i_fetch_req,
    input  wire [soc_mem_pkg::ADDR_W-1:0]   i_fetch_addr,
    output logic                            o_fetch_ack,
    output logic [soc_mem_pkg::DATA_W-1:0]  o_fetch_data,
    input  wire                             i_data_rd,
    input  wire                             i_data_wr,
    input  wire [soc_mem_pkg::ADDR_W-1:0]   i_data_addr,
    input  wire [soc_mem_pkg::DATA_W-1:0]   i_data_wdata,
    output logic                            o_data_ack,
    output logic [soc_mem_pkg::DATA_W-1:0]  o_data_rdata,
    output logic                            o_req_valid,
    input  wire                             i_req_ready,
    output logic                            o_req_write,
    output logic                            o_req_fetch,
    output logic [soc_mem_pkg::ADDR_W-1:0]  o_req_addr,
    output logic [soc_mem_pkg::DATA_W-1:0]  o_req_wdata,
    input  wire                             i_rsp_valid,
    input  wire [soc_mem_pkg::DATA_W-1:0]   i_rsp_rdata
);
    import soc_mem_pkg::*;

    arb_state_e        state_q;
    logic              gnt_data_q;
    logic [DATA_W-1:0] rdata_q;
    logic              data_req;
    logic              ack_busy;
    logic              sample;

    assign data_req = i_data_rd | i_data_wr;
    // requester still holds its level during the ack cycle
    assign ack_busy = o_fetch_ack | o_data_ack;
    assign sample   = (state_q == ARB_IDLE) && !ack_busy;

    assign o_req_valid = (state_q == ARB_REQ);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q     <= ARB_IDLE;
            gnt_data_q  <= 1'b0;
            o_fetch_ack <= 1'b0;
            o_data_ack  <= 1'b0;
        end else begin
            o_fetch_ack <= 1'b0;
            o_data_ack  <= 1'b0;
            case (state_q)
                ARB_IDLE: begin
                    if (sample && (data_req || i_fetch_req)) begin
                        gnt_data_q <= data_req;
                        state_q    <= ARB_REQ;
                    end
                end
                ARB_REQ: begin
                    if (i_req_ready) begin
                        state_q <= ARB_WAIT;
                    end
                end
                ARB_WAIT: begin
                    if (i_rsp_valid) begin
                        o_data_ack  <= gnt_data_q;
                        o_fetch_ack <= !gnt_data_q;
                        state_q     <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // latch the winning command, data port first
    always_ff @(posedge clk) begin
        if (sample) begin
            o_req_write <= data_req && i_data_wr;
            o_req_fetch <= !data_req;
            o_req_addr  <= data_req ? i_data_addr : i_fetch_addr;
            o_req_wdata <= i_data_wdata;
        end
        if ((state_q == ARB_WAIT) && i_rsp_valid) begin
            rdata_q <= i_rsp_rdata;
        end
    end

    // only the acked port looks at its data
    assign o_fetch_data = rdata_q;
    assign o_data_rdata = rdata_q;

    a_one_ack: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(o_fetch_ack && o_data_ack));

    a_one_outstanding: assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_req_valid && i_req_ready) |=> !o_req_valid until_with i_rsp_valid);

endmodule

`default_nettype wire

// File: hdl/bus_decoder.sv
// address decoder for the internal bus
// routes requests to the timer or the RAM bridge and returns the reply
`timescale 1ns/1ns
`default_nettype none

module bus_decoder (
    input  wire                             clk,
    input  wire                             i_arst_n,
    input  wire                             i_req_valid,
    output logic                            o_req_ready,
    input  wire                             i_req_write,
    input  wire                             i_req_fetch,
    input  wire [soc_mem_pkg::ADDR_W-1:0]   i_req_addr,
    input  wire [soc_mem_pkg::DATA_W-1:0]   i_req_wdata,
    output logic                            o_rsp_valid,
    output logic [soc_mem_pkg::DATA_W-1:0]  o_rsp_rdata,
    output logic                            o_ram_req_valid,
    input  wire                             i_ram_req_ready,
    output logic                            o_ram_req_write,
    output logic                            o_ram_req_fetch,
    output logic [soc_mem_pkg::ADDR_W-1:0]  o_ram_req_addr,
    output logic [soc_mem_pkg::DATA_W-1:0]  o_ram_req_wdata,
    input  wire                             i_ram_rsp_valid,
    input  wire [soc_mem_pkg::DATA_W-1:0]   i_ram_rsp_rdata,
    output logic                            o_tmr_req_valid,
    input  wire                             i_tmr_req_ready,
    output logic                            o_tmr_req_write,
    output logic [soc_mem_pkg::ADDR_W-1:0]  o_tmr_req_addr,
    output logic [soc_mem_pkg::DATA_W-1:0]  o_tmr_req_wdata,
    input  wire                             i_tmr_rsp_valid,
    input  wire [soc_mem_pkg::DATA_W-1:0]   i_tmr_rsp_rdata
);
    import soc_mem_pkg::*;

    bus_target_e tgt_sel;
    bus_target_e tgt_q;
    logic        busy_q;
    logic        xfer;

    // timer owns exactly two addresses, everything else is RAM
    assign tgt_sel = ((i_req_addr == MTIME_ADDR) || (i_req_addr == MTIMECMP_ADDR)) ?
                     TGT_TIMER : TGT_RAM;

    assign o_ram_req_valid = i_req_valid && (tgt_sel == TGT_RAM);
    assign o_ram_req_write = i_req_write;
    assign o_ram_req_fetch = i_req_fetch;
    assign o_ram_req_addr  = i_req_addr;
    assign o_ram_req_wdata = i_req_wdata;

    assign o_tmr_req_valid = i_req_valid && (tgt_sel == TGT_TIMER);
    assign o_tmr_req_write = i_req_write;
    assign o_tmr_req_addr  = i_req_addr;
    assign o_tmr_req_wdata = i_req_wdata;

    assign o_req_ready = (tgt_sel == TGT_TIMER) ? i_tmr_req_ready : i_ram_req_ready;
    assign xfer        = i_req_valid && o_req_ready;

    // target of the transfer in flight
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            tgt_q  <= TGT_RAM;
            busy_q <= 1'b0;
        end else if (xfer) begin
            tgt_q  <= tgt_sel;
            busy_q <= 1'b1;
        end else if (o_rsp_valid) begin
            busy_q <= 1'b0;
        end
    end

    assign o_rsp_valid = (tgt_q == TGT_TIMER) ? i_tmr_rsp_valid : i_ram_rsp_valid;
    assign o_rsp_rdata = (tgt_q == TGT_TIMER) ? i_tmr_rsp_rdata : i_ram_rsp_rdata;

    a_rsp_outstanding: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_rsp_valid |-> busy_q);

endmodule

`default_nettype wire

// File: hdl/ram_bridge.sv
// internal bus to external RAM pin adapter
// instruction reads, data reads and data writes, one beat each
`timescale 1ns/1ns
`default_nettype none

module ram_bridge (
    input  wire                             clk,
    input  wire                             i_arst_n,
    input  wire                             i_req_valid,
    output logic                            o_req_ready,
    input  wire                             i_req_write,
    input  wire                             i_req_fetch,
    input  wire [soc_mem_pkg::ADDR_W-1:0]   i_req_addr,
    input  wire [soc_mem_pkg::DATA_W-1:0]   i_req_wdata,
    output logic                            o_rsp_valid,
    output logic [soc_mem_pkg::DATA_W-1:0]  o_rsp_rdata,
    output logic                            o_read_ram_ena,
    output logic                            o_read_inst_ena,
    output logic [soc_mem_pkg::ADDR_W-1:0]  o_addr_outp,
    input  wire [soc_mem_pkg::DATA_W-1:0]   i_inst_data_in,
    input  wire [soc_mem_pkg::DATA_W-1:0]   i_ram_data_in,
    output logic                            o_write_ram_ena,
    output logic [soc_mem_pkg::DATA_W-1:0]  o_write_ram_data,
    output logic [soc_mem_pkg::ADDR_W-1:0]  o_write_ram_addr
);
    import soc_mem_pkg::*;

    bridge_state_e     state_q;
    logic              fetch_q;
    logic [ADDR_W-1:0] addr_q;
    logic              xfer;

    assign o_req_ready = (state_q == BR_IDLE);
    assign xfer        = i_req_valid && o_req_ready;

    // write: IDLE -> RESP, read: IDLE -> READ -> RESP
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= BR_IDLE;
        end else begin
            case (state_q)
                BR_IDLE: begin
                    if (xfer) begin
                        state_q <= i_req_write ? BR_RESP : BR_READ;
                    end
                end
                BR_READ: state_q <= BR_RESP;
                BR_RESP: state_q <= BR_IDLE;
                default: state_q <= BR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            fetch_q <= i_req_fetch;
            addr_q  <= i_req_addr;
        end
    end

    // write strobe goes out in the transfer cycle itself
    assign o_write_ram_ena  = xfer && i_req_write;
    assign o_write_ram_addr = i_req_addr;
    assign o_write_ram_data = i_req_wdata;

    assign o_read_inst_ena = (state_q == BR_READ) && fetch_q;
    assign o_read_ram_ena  = (state_q == BR_READ) && !fetch_q;
    assign o_addr_outp     = addr_q;

    // RAM answers one cycle after the read enable
    assign o_rsp_valid = (state_q == BR_RESP);
    assign o_rsp_rdata = fetch_q ? i_inst_data_in : i_ram_data_in;

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(o_write_ram_ena && (o_read_ram_ena || o_read_inst_ena)));

endmodule

`default_nettype wire

// File: hdl/clint_timer.sv
// core-local timer
// free-running MTIME, writable MTIMECMP, registered timer interrupt
`timescale 1ns/1ns
`default_nettype none

module clint_timer (
    input  wire                             clk,
    input  wire                             i_arst_n,
    input  wire                             i_req_valid,
    output logic                            o_req_ready,
    input  wire                             i_req_write,
    input  wire [soc_mem_pkg::ADDR_W-1:0]   i_req_addr,
    input  wire [soc_mem_pkg::DATA_W-1:0]   i_req_wdata,
    output logic                            o_rsp_valid,
    output logic [soc_mem_pkg::DATA_W-1:0]  o_rsp_rdata,
    output logic                            o_timer_intr
);
    import soc_mem_pkg::*;

    logic [DATA_W-1:0] mtime_q;
    logic [DATA_W-1:0] mtimecmp_q;
    logic              wr_mtime;
    logic              wr_cmp;

    // never stalls the bus
    assign o_req_ready = 1'b1;

    assign wr_mtime = i_req_valid && i_req_write && (i_req_addr == MTIME_ADDR);
    assign wr_cmp   = i_req_valid && i_req_write && (i_req_addr == MTIMECMP_ADDR);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mtime_q      <= '0;
            mtimecmp_q   <= '1;
            o_rsp_valid  <= 1'b0;
            o_timer_intr <= 1'b0;
        end else begin
            mtime_q      <= wr_mtime ? i_req_wdata : mtime_q + 1'b1;
            if (wr_cmp) begin
                mtimecmp_q <= i_req_wdata;
            end
            o_rsp_valid  <= i_req_valid;
            // level interrupt, held until MTIMECMP moves past MTIME
            o_timer_intr <= (mtime_q >= mtimecmp_q);
        end
    end

    // read data captured at the transfer
    always_ff @(posedge clk) begin
        if (i_req_valid && !i_req_write) begin
            o_rsp_rdata <= (i_req_addr == MTIME_ADDR) ? mtime_q : mtimecmp_q;
        end
    end

endmodule

`default_nettype wire

// File: hdl/soc_mem_top.sv
// memory subsystem top level
// arbiter, address decoder, RAM pin bridge and core-local timer
`timescale 1ns/1ns
`default_nettype none

module soc_mem_top (
    input  wire                             clk,
    input  wire                             i_arst_n,
    // instruction fetch port
    input  wire                             i_fetch_req,
    input  wire [soc_mem_pkg::ADDR_W-1:0]   i_fetch_addr,
    output logic                            o_fetch_ack,
    output logic [soc_mem_pkg::DATA_W-1:0]  o_fetch_data,
    // data port
    input  wire                             i_data_rd,
    input  wire                             i_data_wr,
    input  wire [soc_mem_pkg::ADDR_W-1:0]   i_data_addr,
    input  wire [soc_mem_pkg::DATA_W-1:0]   i_data_wdata,
    output logic                            o_data_ack,
    output logic [soc_mem_pkg::DATA_W-1:0]  o_data_rdata,
    // external RAM pins
    output logic                            o_read_ram_ena,
    output logic                            o_read_inst_ena,
    output logic [soc_mem_pkg::ADDR_W-1:0]  o_addr_outp,
    input  wire [soc_mem_pkg::DATA_W-1:0]   i_inst_data_in,
    input  wire [soc_mem_pkg::DATA_W-1:0]   i_ram_data_in,
    output logic                            o_write_ram_ena,
    output logic [soc_mem_pkg::DATA_W-1:0]  o_write_ram_data,
    output logic [soc_mem_pkg::ADDR_W-1:0]  o_write_ram_addr,
    // machine timer interrupt
    output logic                            o_timer_intr
);

    // arbiter to decoder
    logic                            bus_req_valid;
    logic                            bus_req_ready;
    logic                            bus_req_write;
    logic                            bus_req_fetch;
    logic [soc_mem_pkg::ADDR_W-1:0]  bus_req_addr;
    logic [soc_mem_pkg::DATA_W-1:0]  bus_req_wdata;
    logic                            bus_rsp_valid;
    logic [soc_mem_pkg::DATA_W-1:0]  bus_rsp_rdata;

    // decoder to RAM bridge
    logic                            ram_req_valid;
    logic                            ram_req_ready;
    logic                            ram_req_write;
    logic                            ram_req_fetch;
    logic [soc_mem_pkg::ADDR_W-1:0]  ram_req_addr;
    logic [soc_mem_pkg::DATA_W-1:0]  ram_req_wdata;
    logic                            ram_rsp_valid;
    logic [soc_mem_pkg::DATA_W-1:0]  ram_rsp_rdata;

    // decoder to timer
    logic                            tmr_req_valid;
    logic                            tmr_req_ready;
    logic                            tmr_req_write;
    logic [soc_mem_pkg::ADDR_W-1:0]  tmr_req_addr;
    logic [soc_mem_pkg::DATA_W-1:0]  tmr_req_wdata;
    logic                            tmr_rsp_valid;
    logic [soc_mem_pkg::DATA_W-1:0]  tmr_rsp_rdata;

    mem_arbiter u_mem_arbiter (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_fetch_req  (i_fetch_req),
        .i_fetch_addr (i_fetch_addr),
        .o_fetch_ack  (o_fetch_ack),
        .o_fetch_data (o_fetch_data),
        .i_data_rd    (i_data_rd),
        .i_data_wr    (i_data_wr),
        .i_data_addr  (i_data_addr),
        .i_data_wdata (i_data_wdata),
        .o_data_ack   (o_data_ack),
        .o_data_rdata (o_data_rdata),
        .o_req_valid  (bus_req_valid),
        .i_req_ready  (bus_req_ready),
        .o_req_write  (bus_req_write),
        .o_req_fetch  (bus_req_fetch),
        .o_req_addr   (bus_req_addr),
        .o_req_wdata  (bus_req_wdata),
        .i_rsp_valid  (bus_rsp_valid),
        .i_rsp_rdata  (bus_rsp_rdata)
    );

    bus_decoder u_bus_decoder (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_req_valid     (bus_req_valid),
        .o_req_ready     (bus_req_ready),
        .i_req_write     (bus_req_write),
        .i_req_fetch     (bus_req_fetch),
        .i_req_addr      (bus_req_addr),
        .i_req_wdata     (bus_req_wdata),
        .o_rsp_valid     (bus_rsp_valid),
        .o_rsp_rdata     (bus_rsp_rdata),
        .o_ram_req_valid (ram_req_valid),
        .i_ram_req_ready (ram_req_ready),
        .o_ram_req_write (ram_req_write),
        .o_ram_req_fetch (ram_req_fetch),
        .o_ram_req_addr  (ram_req_addr),
        .o_ram_req_wdata (ram_req_wdata),
        .i_ram_rsp_valid (ram_rsp_valid),
        .i_ram_rsp_rdata (ram_rsp_rdata),
        .o_tmr_req_valid (tmr_req_valid),
        .i_tmr_req_ready (tmr_req_ready),
        .o_tmr_req_write (tmr_req_write),
        .o_tmr_req_addr  (tmr_req_addr),
        .o_tmr_req_wdata (tmr_req_wdata),
        .i_tmr_rsp_valid (tmr_rsp_valid),
        .i_tmr_rsp_rdata (tmr_rsp_rdata)
    );

    ram_bridge u_ram_bridge (
        .clk              (clk),
        .i_arst_n         (i_arst_n),
        .i_req_valid      (ram_req_valid),
        .o_req_ready      (ram_req_ready),
        .i_req_write      (ram_req_write),
        .i_req_fetch      (ram_req_fetch),
        .i_req_addr       (ram_req_addr),
        .i_req_wdata      (ram_req_wdata),
        .o_rsp_valid      (ram_rsp_valid),
        .o_rsp_rdata      (ram_rsp_rdata),
        .o_read_ram_ena   (o_read_ram_ena),
        .o_read_inst_ena  (o_read_inst_ena),
        .o_addr_outp      (o_addr_outp),
        .i_inst_data_in   (i_inst_data_in),
        .i_ram_data_in    (i_ram_data_in),
        .o_write_ram_ena  (o_write_ram_ena),
        .o_write_ram_data (o_write_ram_data),
        .o_write_ram_addr (o_write_ram_addr)
    );

    clint_timer u_clint_timer (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_req_valid  (tmr_req_valid),
        .o_req_ready  (tmr_req_ready),
        .i_req_write  (tmr_req_write),
        .i_req_addr   (tmr_req_addr),
        .i_req_wdata  (tmr_req_wdata),
        .o_rsp_valid  (tmr_rsp_valid),
        .o_rsp_rdata  (tmr_rsp_rdata),
        .o_timer_intr (o_timer_intr)
    );

endmodule

`default_nettype wire

// File: tb/tb_soc_mem_top.sv
// testbench for the memory subsystem top level
// RAM pin model, pattern-driven RAM tests, arbitration and timer tests
`timescale 1ns/1ns
`default_nettype none

module tb_soc_mem_top;
    import soc_mem_pkg::*;

    localparam int          PAT_N    = 11;
    localparam int          TIMEOUT  = 40;
    localparam logic [63:0] INST_XOR = 64'hA5A5_0000_0000_0000;

    logic              clk;
    logic              i_arst_n;
    logic              i_fetch_req;
    logic              i_data_rd;
    logic              i_data_wr;
    logic [ADDR_W-1:0] i_fetch_addr;
    logic [ADDR_W-1:0] i_data_addr;
    logic [DATA_W-1:0] i_data_wdata;
    logic [DATA_W-1:0] i_inst_data_in;
    logic [DATA_W-1:0] i_ram_data_in;
    logic              o_fetch_ack;
    logic              o_data_ack;
    logic              o_read_ram_ena;
    logic              o_read_inst_ena;
    logic              o_write_ram_ena;
    logic              o_timer_intr;
    logic [DATA_W-1:0] o_fetch_data;
    logic [DATA_W-1:0] o_data_rdata;
    logic [DATA_W-1:0] o_write_ram_data;
    logic [ADDR_W-1:0] o_addr_outp;
    logic [ADDR_W-1:0] o_write_ram_addr;

    // four words per line for op, address, write data and expected value
    logic [63:0] pat [0:4*PAT_N-1];
    logic [63:0] wr_addr_q[$];
    logic [63:0] wr_data_q[$];
    logic [63:0] last_rd_addr;
    logic [63:0] last_wr_addr;
    logic [63:0] last_wr_data;
    int          inst_pulses = 0;
    int          ram_rd_pulses = 0;
    int          wr_pulses = 0;
    int          cycle = 0;
    int          ack_cycle = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    soc_mem_top u_soc_mem_top (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // last write to an address wins and unwritten words read back inverted
    function automatic logic [63:0] ram_lookup(input logic [63:0] addr);
        logic [63:0] val;
        val = ~addr;
        foreach (wr_addr_q[i]) begin
            if (wr_addr_q[i] == addr) begin
                val = wr_data_q[i];
            end
        end
        return val;
    endfunction

    // RAM model and enable monitor
    always @(negedge clk) begin
        if (o_read_inst_ena) begin
            i_inst_data_in = o_addr_outp ^ INST_XOR;
            inst_pulses++;
            last_rd_addr = o_addr_outp;
        end
        if (o_read_ram_ena) begin
            i_ram_data_in = ram_lookup(o_addr_outp);
            ram_rd_pulses++;
            last_rd_addr = o_addr_outp;
        end
        if (o_write_ram_ena) begin
            wr_addr_q.push_back(o_write_ram_addr);
            wr_data_q.push_back(o_write_ram_data);
            wr_pulses++;
            last_wr_addr = o_write_ram_addr;
            last_wr_data = o_write_ram_data;
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // op is 0 for data read, 1 for data write and 2 for fetch
    task automatic port_access(input int op, input logic [63:0] addr,
                               input logic [63:0] wdata, output logic [63:0] rdata);
        int n;
        @(negedge clk);
        i_fetch_req  = (op == 2);
        i_fetch_addr = addr;
        i_data_rd    = (op == 0);
        i_data_wr    = (op == 1);
        i_data_addr  = addr;
        i_data_wdata = wdata;
        n = 0;
        @(negedge clk);
        while (!(o_fetch_ack || o_data_ack) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!(o_fetch_ack || o_data_ack)) begin
            $display("error: request to address %h was never acknowledged", addr);
            errors++;
        end else begin
            check("o_fetch_ack", o_fetch_ack, op == 2);
            check("o_data_ack", o_data_ack, op != 2);
        end
        rdata       = (op == 2) ? o_fetch_data : o_data_rdata;
        ack_cycle   = cycle;
        i_fetch_req = 1'b0;
        i_data_rd   = 1'b0;
        i_data_wr   = 1'b0;
    endtask

    task automatic wait_intr_level(input logic level);
        int n;
        n = 0;
        while (o_timer_intr !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        check("o_timer_intr", o_timer_intr, level);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: failed", tests_run, name);
            tests_failed++;
        end
        test_errors = errors;
    endtask

    initial begin
        logic [63:0] rd;
        logic [63:0] rd2;
        logic [63:0] addr;
        logic [63:0] wdata;
        int          seed;
        int          c0;
        int          c1;
        int          n;
        logic        got_f;
        logic        got_d;
        logic        data_first;
        clk            = 1'b0;
        i_arst_n       = 1'b0;
        i_fetch_req    = 1'b0;
        i_fetch_addr   = '0;
        i_data_rd      = 1'b0;
        i_data_wr      = 1'b0;
        i_data_addr    = '0;
        i_data_wdata   = '0;
        i_inst_data_in = '0;
        i_ram_data_in  = '0;
        seed = $urandom(32'hd4ff);
        $readmemh("tb/soc_mem_patterns.txt", pat);
        repeat (2) @(negedge clk);
        i_arst_n = 1'b1;
        check("o_fetch_ack", o_fetch_ack, 0);
        check("o_data_ack", o_data_ack, 0);
        check("o_read_ram_ena", o_read_ram_ena, 0);
        check("o_read_inst_ena", o_read_inst_ena, 0);
        check("o_write_ram_ena", o_write_ram_ena, 0);
        check("o_timer_intr", o_timer_intr, 0);

        c0 = ram_rd_pulses;
        c1 = inst_pulses;
        port_access(2, 64'h0000_0000_0000_0840, 64'h0, rd);
        check("o_fetch_data", rd, 64'hA5A5_0000_0000_0840);
        check("o_read_inst_ena pulses", inst_pulses - c1, 1);
        check("o_addr_outp", last_rd_addr, 64'h0000_0000_0000_0840);
        check("o_read_ram_ena pulses", ram_rd_pulses - c0, 0);
        finish_test("fetch");

        c1 = wr_pulses;
        port_access(1, 64'h0000_0000_0000_0100, 64'h0123_4567_89AB_CDEF, rd);
        check("o_write_ram_ena pulses", wr_pulses - c1, 1);
        check("o_write_ram_addr", last_wr_addr, 64'h0000_0000_0000_0100);
        check("o_write_ram_data", last_wr_data, 64'h0123_4567_89AB_CDEF);
        c0 = ram_rd_pulses;
        port_access(0, 64'h0000_0000_0000_0100, 64'h0, rd);
        check("o_data_rdata", rd, 64'h0123_4567_89AB_CDEF);
        check("o_read_ram_ena pulses", ram_rd_pulses - c0, 1);
        check("o_addr_outp", last_rd_addr, 64'h0000_0000_0000_0100);
        finish_test("write then read");

        // data wins when both ports request together
        @(negedge clk);
        i_fetch_req  = 1'b1;
        i_fetch_addr = 64'h0000_0000_0000_2200;
        i_data_rd    = 1'b1;
        i_data_addr  = 64'h0000_0000_0000_0100;
        n          = 0;
        got_f      = 1'b0;
        got_d      = 1'b0;
        data_first = 1'b0;
        while (!(got_f && got_d) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            if (o_data_ack) begin
                got_d      = 1'b1;
                data_first = !got_f;
                rd         = o_data_rdata;
                i_data_rd  = 1'b0;
            end
            if (o_fetch_ack) begin
                got_f       = 1'b1;
                rd2         = o_fetch_data;
                i_fetch_req = 1'b0;
            end
        end
        if (!(got_f && got_d)) begin
            $display("error: concurrent fetch and data read did not both complete");
            errors++;
        end
        i_fetch_req = 1'b0;
        i_data_rd   = 1'b0;
        check("data ack first", data_first, 1);
        check("o_data_rdata", rd, 64'h0123_4567_89AB_CDEF);
        check("o_fetch_data", rd2, 64'hA5A5_0000_0000_2200);
        finish_test("fetch and data contention");

        for (int i = 0; i < PAT_N; i++) begin
            port_access(pat[4*i], pat[4*i+1], pat[4*i+2], rd);
            if (pat[4*i] == 64'h2) begin
                check("o_fetch_data", rd, pat[4*i+3]);
            end else if (pat[4*i] == 64'h0) begin
                check("o_data_rdata", rd, pat[4*i+3]);
            end
        end
        repeat (8) begin
            addr        = {$urandom, $urandom};
            addr[63:62] = 2'b01;
            wdata       = {$urandom, $urandom};
            port_access(1, addr, wdata, rd);
            port_access(0, addr, 64'h0, rd);
            check("o_data_rdata", rd, wdata);
            // never written region
            addr[63:62] = 2'b11;
            port_access(0, addr, 64'h0, rd);
            check("o_data_rdata", rd, ~addr);
        end
        finish_test("pattern and random RAM");

        c0 = inst_pulses + ram_rd_pulses + wr_pulses;
        port_access(1, MTIMECMP_ADDR, 64'h0, rd);
        wait_intr_level(1'b1);
        port_access(0, MTIMECMP_ADDR, 64'h0, rd);
        check("o_data_rdata", rd, 64'h0);
        port_access(1, MTIMECMP_ADDR, '1, rd);
        wait_intr_level(1'b0);
        check("RAM enables during timer access", inst_pulses + ram_rd_pulses + wr_pulses - c0, 0);
        finish_test("timer compare and interrupt");

        port_access(0, MTIME_ADDR, 64'h0, rd);
        c1 = ack_cycle;
        port_access(0, MTIME_ADDR, 64'h0, rd2);
        check("mtime increases", rd2 > rd, 1);
        check("mtime step vs ack distance", (rd2 - rd) >= 64'(ack_cycle - c1), 1);
        finish_test("mtime counting");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/soc_mem_patterns.txt
// columns: op, address, write data, expected read value (hex)
// op 0 data read, 1 data write, 2 instruction fetch
1 0000000000001000 1122334455667788 0000000000000000
0 0000000000001000 0000000000000000 1122334455667788
0 0000000000002000 0000000000000000 ffffffffffffdfff
2 0000000000003000 0000000000000000 a5a5000000003000
1 80000000deadbe00 cafef00d12345678 0000000000000000
0 80000000deadbe00 0000000000000000 cafef00d12345678
0 0000000012345678 0000000000000000 ffffffffedcba987
2 00000000000001f0 0000000000000000 a5a50000000001f0
1 0000000000001000 0f0f0f0f0f0f0f0f 0000000000000000
0 0000000000001000 0000000000000000 0f0f0f0f0f0f0f0f
0 00000000deadbe00 0000000000000000 ffffffff215241ff

// File: soc_mem_top.f
hdl/soc_mem_pkg.sv
hdl/mem_arbiter.sv
hdl/bus_decoder.sv
hdl/ram_bridge.sv
hdl/clint_timer.sv
hdl/soc_mem_top.sv
tb/tb_soc_mem_top.sv
